//--- vlog.f
+incdir+source
source/dram_pkg.sv
source/dram_reg_wb_attach.sv
source/dram_reset_ctrl.sv
source/dram_indirect_window.sv
source/dram_cpu_interface.sv
tests/dram_phy_model.sv
tests/tb_dram_cpu_interface.sv

//--- run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dram_cpu_interface -Mdir obj_dir -f vlog.f

# the simulator exit code is not trusted; the log decides
./obj_dir/Vtb_dram_cpu_interface > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

//--- tests/tb_dram_cpu_interface.sv
`timescale 1ns/1ps
`include "dram_config.svh"

module tb_dram_cpu_interface;

  // 18 bursts of about 50 bus accesses at 2 cycles each, plus polling, stay far below this
  localparam int MAX_CYCLES = 20000;
  localparam int WORDS = `DRAM_BURST_WORDS;

  logic dram_clk0 = 1'b0;
  logic wb_rst_i;
  logic reg_cyc, reg_stb, reg_ack, mem_cyc, mem_stb, mem_ack;
  dram_pkg::wb_req_t reg_req, mem_req;
  logic [15:0] reg_dat, mem_dat;
  logic phy_rdy, cal_fail, dram_rst, rd_valid;
  dram_pkg::dram_cmd_t dram_cmd;
  logic [`DRAM_BEAT_WIDTH-1:0] rd_data;

  logic [15:0] lfsr_state;
  int cmds_done;
  int cycle_count = 0;
  // reference contents of each burst address
  logic [`DRAM_BURST_BITS-1:0] ref_mem [logic [31:0]];

  always #2 dram_clk0 = ~dram_clk0;

  dram_cpu_interface dut0 (
    .dram_clk0(dram_clk0), .wb_rst_i(wb_rst_i),
    .reg_wb_cyc_i(reg_cyc), .reg_wb_stb_i(reg_stb), .reg_wb_req_i(reg_req),
    .reg_wb_dat_o(reg_dat), .reg_wb_ack_o(reg_ack),
    .mem_wb_cyc_i(mem_cyc), .mem_wb_stb_i(mem_stb), .mem_wb_req_i(mem_req),
    .mem_wb_dat_o(mem_dat), .mem_wb_ack_o(mem_ack),
    .dram_phy_rdy_i(phy_rdy), .dram_cal_fail_i(cal_fail), .dram_rst_o(dram_rst),
    .dram_cmd_o(dram_cmd), .dram_rd_data_i(rd_data), .dram_rd_valid_i(rd_valid)
  );

  dram_phy_model phy0 (
    .dram_clk0(dram_clk0), .dram_rst_i(dram_rst), .cmd_i(dram_cmd), .phy_rdy_o(phy_rdy),
    .cal_fail_o(cal_fail), .rd_data_o(rd_data), .rd_valid_o(rd_valid)
  );

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hb400 : 16'h0000);
  endfunction

  // one LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [47:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
      report_failure($sformatf("CHECK FAILED %s expected %h actual %h", name, exp, act));
    end
  endtask

  always @(posedge dram_clk0) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES) begin
      report_failure($sformatf("timeout after %0d cycles", MAX_CYCLES));
    end
  end

  // one classic cycle with the request held until ack is seen
  task automatic bus_access(input bit reg_port, input bit we, input logic [6:0] idx,
                            input logic [15:0] wdat, output logic [15:0] rdat);
    dram_pkg::wb_req_t req;
    req.we  = we;
    req.sel = 2'b11;
    req.adr = {24'h0, idx, 1'b0};
    req.dat = wdat;
    @(posedge dram_clk0);
    #0.5;
    if (reg_port) begin
      reg_req = req;
      reg_cyc = 1'b1;
      reg_stb = 1'b1;
    end else begin
      mem_req = req;
      mem_cyc = 1'b1;
      mem_stb = 1'b1;
    end
    do begin
      @(posedge dram_clk0);
      #0.5;
    end while (!(reg_port ? reg_ack : mem_ack));
    rdat = reg_port ? reg_dat : mem_dat;
    {reg_cyc, reg_stb, mem_cyc, mem_stb} = 4'b0000;
  endtask

  task automatic mem_write(input logic [6:0] idx, input logic [15:0] d);
    logic [15:0] unused;
    bus_access(1'b0, 1'b1, idx, d, unused);
  endtask

  task automatic mem_read(input logic [6:0] idx, output logic [15:0] d);
    bus_access(1'b0, 1'b0, idx, 16'h0000, d);
  endtask

  task automatic poll_bit(input bit reg_port, input logic [6:0] idx, input logic want,
                          output logic [15:0] v);
    int polls;
    polls = 0;
    v = {15'h0000, !want};
    while (v[0] != want) begin
      bus_access(reg_port, 1'b0, idx, 16'h0000, v);
      polls++;
      assert (polls < 100) else begin
        report_failure($sformatf("bit 0 of index %0d never became %0b", idx, want));
      end
    end
  endtask

  task automatic rand_burst(output logic [`DRAM_BURST_BITS-1:0] d);
    logic [47:0] w;
    for (int k = 0; k < WORDS; k++) begin
      rand_bits(16, w);
      d[16*k +: 16] = w[15:0];
    end
  endtask

  task automatic fill_window(input logic [31:0] addr, input logic [47:0] mask,
                             input logic [`DRAM_BURST_BITS-1:0] data);
    mem_write(7'd2, addr[31:16]);
    mem_write(7'd3, addr[15:0]);
    for (int i = 0; i < 3; i++) begin
      mem_write(7'(5 + i), mask[47-16*i -: 16]);
    end
    for (int k = 0; k < WORDS; k++) begin
      mem_write(7'(8 + k), data[16*k +: 16]);
    end
  endtask

  // bytes whose mask bit is 0 keep their old value
  task automatic model_write(input logic [31:0] addr, input logic [47:0] mask,
                             input logic [`DRAM_BURST_BITS-1:0] data);
    logic [`DRAM_BURST_BITS-1:0] cur;
    cur = '0;
    if (ref_mem.exists(addr)) begin
      cur = ref_mem[addr];
    end
    for (int j = 0; j < `DRAM_BURST_BITS / 8; j++) begin
      if (mask[j]) begin
        cur[8*j +: 8] = data[8*j +: 8];
      end
    end
    ref_mem[addr] = cur;
  endtask

  task automatic write_read_burst(input string name, input logic [31:0] addr,
                                  input logic [47:0] mask,
                                  input logic [`DRAM_BURST_BITS-1:0] data);
    logic [15:0] v;
    logic [`DRAM_BURST_BITS-1:0] exp;
    string kind;
    fill_window(addr, mask, data);
    model_write(addr, mask, data);
    for (int r = 0; r < 2; r++) begin
      if (r == 0) begin
        kind = " write busy";
      end else begin
        kind = " read busy";
      end
      mem_write(7'(r), 16'h0001);
      mem_read(7'(r), v);
      check_equal({name, kind}, 32'h1, 32'(v));
      poll_bit(1'b0, 7'(r), 1'b0, v);
      cmds_done++;
    end
    exp = ref_mem[addr];
    for (int k = 0; k < WORDS; k++) begin
      mem_read(7'(26 + k), v);
      check_equal($sformatf("%s word %0d", name, k), 32'(exp[16*k +: 16]), 32'(v));
    end
  endtask

  initial begin
    logic [15:0] v;
    logic [47:0] w;
    logic [47:0] mask;
    logic [31:0] addr;
    logic [`DRAM_BURST_BITS-1:0] data;
    int n;
    wb_rst_i = 1'b1;
    {reg_cyc, reg_stb, mem_cyc, mem_stb} = 4'b0000;
    reg_req = '0;
    mem_req = '0;
    lfsr_state = 16'd48;
    cmds_done = 0;
    repeat (2) @(posedge dram_clk0);
    #0.5;
    wb_rst_i = 1'b0;

    // PHY reset stretch after system reset and the status that follows
    check_equal("reset high after release", 32'h1, 32'(dram_rst));
    n = 0;
    while (dram_rst) begin
      @(posedge dram_clk0);
      #0.5;
      n++;
    end
    check_equal("reset stretch cycles", 32'd8, 32'(n));
    poll_bit(1'b1, 7'd0, 1'b1, v);
    check_equal("phy status after reset", 32'h1, 32'(v));

    // window registers read back unchanged
    rand_bits(32, w);
    addr = w[31:0];
    rand_bits(48, mask);
    rand_burst(data);
    fill_window(addr, mask, data);
    mem_read(7'd2, v);
    check_equal("address high", 32'(addr[31:16]), 32'(v));
    mem_read(7'd3, v);
    check_equal("address low", 32'(addr[15:0]), 32'(v));
    for (int i = 0; i < 3; i++) begin
      mem_read(7'(5 + i), v);
      check_equal($sformatf("mask word %0d", i), 32'(mask[47-16*i -: 16]), 32'(v));
    end
    for (int k = 0; k < WORDS; k++) begin
      mem_read(7'(8 + k), v);
      check_equal($sformatf("write buffer %0d", k), 32'(data[16*k +: 16]), 32'(v));
    end
    // reserved index keeps nothing of a write
    mem_write(7'd4, 16'hffff);
    mem_read(7'd4, v);
    check_equal("reserved index", 32'h0, 32'(v));

    for (int t = 0; t < 16; t++) begin
      rand_bits(32, w);
      addr = w[31:0];
      rand_bits(48, mask);
      rand_burst(data);
      write_read_burst($sformatf("burst %0d", t), addr, mask, data);
    end

    // soft reset through the register port
    bus_access(1'b1, 1'b1, 7'd0, 16'h0001, v);
    n = 0;
    while (!dram_rst) begin
      @(posedge dram_clk0);
      #0.5;
      n++;
      assert (n < 4) else report_failure("soft reset did not raise dram_rst_o");
    end
    bus_access(1'b1, 1'b0, 7'd0, 16'h0000, v);
    check_equal("phy status in soft reset", 32'h0, 32'(v));
    rand_bits(32, w);
    addr = w[31:0];
    rand_bits(48, mask);
    rand_burst(data);
    write_read_burst("after soft reset", addr, mask, data);

    bus_access(1'b1, 1'b0, 7'd1, 16'h0000, v);
    check_equal("command counter", 32'(cmds_done[15:0]), 32'(v));

    $display("** PASS **");
    $finish;
  end

endmodule

//--- tests/dram_phy_model.sv
`timescale 1ns/1ps
`include "dram_config.svh"

module dram_phy_model (
  input  logic                        dram_clk0,
  input  logic                        dram_rst_i,
  input  dram_pkg::dram_cmd_t         cmd_i,
  output logic                        phy_rdy_o,
  output logic                        cal_fail_o,
  output logic [`DRAM_BEAT_WIDTH-1:0] rd_data_o,
  output logic                        rd_valid_o
);

  localparam int BEAT_W = `DRAM_BEAT_WIDTH;
  localparam int BE_W   = `DRAM_BE_WIDTH;

  // sparse storage, one entry per beat, keyed by {address, beat}
  logic [BEAT_W-1:0] mem [logic [32:0]];
  logic [2:0]        rdy_cnt;
  logic [1:0]        rd_step;
  logic [31:0]       rd_addr;
  logic              wr_hi;
  logic [31:0]       wr_addr;

  task automatic store_beat(input logic [32:0] key, input logic [BEAT_W-1:0] d,
                            input logic [BE_W-1:0] be);
    logic [BEAT_W-1:0] cur;
    cur = '0;
    if (mem.exists(key)) begin
      cur = mem[key];
    end
    for (int i = 0; i < BE_W; i++) begin
      if (be[i]) begin
        cur[8*i +: 8] = d[8*i +: 8];
      end
    end
    mem[key] = cur;
  endtask

  function automatic logic [BEAT_W-1:0] load_beat(input logic [32:0] key);
    if (mem.exists(key)) begin
      return mem[key];
    end
    return '0;
  endfunction

  initial begin
    rdy_cnt    = 3'd0;
    rd_step    = 2'd0;
    rd_addr    = 32'h0;
    wr_hi      = 1'b0;
    wr_addr    = 32'h0;
    rd_data_o  = '0;
    rd_valid_o = 1'b0;
  end

  assign cal_fail_o = 1'b0;
  // calibration pretends to take four cycles
  assign phy_rdy_o  = (rdy_cnt == 3'd4) && !dram_rst_i;

  always @(posedge dram_clk0) begin
    if (dram_rst_i) begin
      rdy_cnt <= 3'd0;
    end else if (rdy_cnt != 3'd4) begin
      rdy_cnt <= rdy_cnt + 3'd1;
    end
  end

  always @(posedge dram_clk0) begin
    // high half of a write follows its command by one cycle
    if (wr_hi) begin
      store_beat({wr_addr, 1'b1}, cmd_i.wr_data, cmd_i.wr_be);
    end
    wr_hi <= 1'b0;
    if (cmd_i.valid && !cmd_i.rnw) begin
      store_beat({cmd_i.addr, 1'b0}, cmd_i.wr_data, cmd_i.wr_be);
      wr_hi   <= 1'b1;
      wr_addr <= cmd_i.addr;
    end
    // read beats seen by the DUT 3 and 4 cycles after the command
    rd_valid_o <= 1'b0;
    if (rd_step == 2'd2 || rd_step == 2'd3) begin
      rd_valid_o <= 1'b1;
      rd_data_o  <= load_beat({rd_addr, rd_step[0]});
    end
    if (rd_step == 2'd3) begin
      rd_step <= 2'd0;
    end else if (rd_step != 2'd0) begin
      rd_step <= rd_step + 2'd1;
    end
    if (cmd_i.valid && cmd_i.rnw) begin
      rd_step <= 2'd1;
      rd_addr <= cmd_i.addr;
    end
  end

endmodule

//--- source/dram_cpu_interface.sv
`timescale 1ns/1ps
`include "dram_config.svh"

module dram_cpu_interface (
  input  logic                        dram_clk0,
  input  logic                        wb_rst_i,
  // register port
  input  logic                        reg_wb_cyc_i,
  input  logic                        reg_wb_stb_i,
  input  dram_pkg::wb_req_t           reg_wb_req_i,
  output logic [15:0]                 reg_wb_dat_o,
  output logic                        reg_wb_ack_o,
  // memory window port
  input  logic                        mem_wb_cyc_i,
  input  logic                        mem_wb_stb_i,
  input  dram_pkg::wb_req_t           mem_wb_req_i,
  output logic [15:0]                 mem_wb_dat_o,
  output logic                        mem_wb_ack_o,
  // PHY and application interface
  input  logic                        dram_phy_rdy_i,
  input  logic                        dram_cal_fail_i,
  output logic                        dram_rst_o,
  output dram_pkg::dram_cmd_t         dram_cmd_o,
  input  logic [`DRAM_BEAT_WIDTH-1:0] dram_rd_data_i,
  input  logic                        dram_rd_valid_i
);

  dram_pkg::dram_status_t phy_status;
  logic                   soft_rst;
  logic                   cmd_done;

  assign phy_status.phy_ready = dram_phy_rdy_i;
  assign phy_status.cal_fail  = dram_cal_fail_i;

  dram_reg_wb_attach reg_wb_attach0 (
    .dram_clk0  (dram_clk0),
    .wb_rst_i   (wb_rst_i),
    .wb_cyc_i   (reg_wb_cyc_i),
    .wb_stb_i   (reg_wb_stb_i),
    .wb_req_i   (reg_wb_req_i),
    .wb_dat_o   (reg_wb_dat_o),
    .wb_ack_o   (reg_wb_ack_o),
    .status_i   (phy_status),
    .cmd_done_i (cmd_done),
    .soft_rst_o (soft_rst)
  );

  // system or soft reset, stretched for the PHY
  dram_reset_ctrl reset_ctrl0 (
    .dram_clk0  (dram_clk0),
    .wb_rst_i   (wb_rst_i),
    .soft_rst_i (soft_rst),
    .dram_rst_o (dram_rst_o)
  );

  dram_indirect_window indirect_window0 (
    .dram_clk0       (dram_clk0),
    .wb_rst_i        (wb_rst_i),
    .wb_cyc_i        (mem_wb_cyc_i),
    .wb_stb_i        (mem_wb_stb_i),
    .wb_req_i        (mem_wb_req_i),
    .wb_dat_o        (mem_wb_dat_o),
    .wb_ack_o        (mem_wb_ack_o),
    .phy_ready_i     (dram_phy_rdy_i),
    .dram_rst_i      (dram_rst_o),
    .dram_cmd_o      (dram_cmd_o),
    .dram_rd_data_i  (dram_rd_data_i),
    .dram_rd_valid_i (dram_rd_valid_i),
    .cmd_done_o      (cmd_done)
  );

endmodule

//--- source/dram_indirect_window.sv
`timescale 1ns/1ps
`include "dram_config.svh"

module dram_indirect_window (
  input  logic                        dram_clk0,
  input  logic                        wb_rst_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  dram_pkg::wb_req_t           wb_req_i,
  output logic [15:0]                 wb_dat_o,
  output logic                        wb_ack_o,
  input  logic                        phy_ready_i,
  input  logic                        dram_rst_i,
  output dram_pkg::dram_cmd_t         dram_cmd_o,
  input  logic [`DRAM_BEAT_WIDTH-1:0] dram_rd_data_i,
  input  logic                        dram_rd_valid_i,
  output logic                        cmd_done_o
);

  localparam int BEAT_W  = `DRAM_BEAT_WIDTH;
  localparam int BURST_W = `DRAM_BURST_BITS;
  localparam int BE_W    = `DRAM_BE_WIDTH;
  localparam int MASK_W  = `DRAM_MASK_WORDS * 16;

  // word index map of the window
  localparam int WR_BASE = 8;
  localparam int RD_BASE = WR_BASE + `DRAM_BURST_WORDS;
  localparam int RD_END  = RD_BASE + `DRAM_BURST_WORDS;

  // issue sequencer states
  localparam logic [1:0] ST_IDLE    = 2'd0;
  localparam logic [1:0] ST_CMD     = 2'd1;
  localparam logic [1:0] ST_WR_HI   = 2'd2;
  localparam logic [1:0] ST_RD_WAIT = 2'd3;

  logic [31:0]      addr_buf;
  logic [MASK_W-1:0] mask_buf;
  logic [BURST_W-1:0] wr_buf;
  logic [BURST_W-1:0] rd_buf;

  logic       wr_busy;
  logic       rd_busy;
  logic [1:0] state;
  logic       cur_rnw;
  logic       rd_beat;
  logic       issue;
  logic       beat_hi;

  logic [6:0] idx;
  logic [6:0] wr_word;
  logic [6:0] rd_word;
  logic       accept;
  logic       wr_access;

  // only the enabled byte lanes of a bus word are replaced
  function automatic logic [15:0] lane_merge(input logic [15:0] old_w,
                                             input logic [15:0] new_w,
                                             input logic [1:0]  sel);
    logic [15:0] res;
    res = old_w;
    if (sel[0]) begin
      res[7:0] = new_w[7:0];
    end
    if (sel[1]) begin
      res[15:8] = new_w[15:8];
    end
    return res;
  endfunction

  assign idx       = wb_req_i.adr[7:1];
  assign wr_word   = idx - 7'(WR_BASE);
  assign rd_word   = idx - 7'(RD_BASE);
  assign accept    = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wr_access = accept & wb_req_i.we;

  always_ff @(posedge dram_clk0) begin
    if (wb_rst_i) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= accept;
    end
  end

  // bus read mux, registered into the ack cycle
  always_ff @(posedge dram_clk0) begin
    if (accept && !wb_req_i.we) begin
      case (idx) inside
        7'd0: wb_dat_o <= {15'h0000, wr_busy};
        7'd1: wb_dat_o <= {15'h0000, rd_busy};
        7'd2: wb_dat_o <= addr_buf[31:16];
        7'd3: wb_dat_o <= addr_buf[15:0];
        7'd5: wb_dat_o <= mask_buf[47:32];
        7'd6: wb_dat_o <= mask_buf[31:16];
        7'd7: wb_dat_o <= mask_buf[15:0];
        [WR_BASE:RD_BASE-1]: wb_dat_o <= wr_buf[wr_word*16 +: 16];
        [RD_BASE:RD_END-1]: wb_dat_o <= rd_buf[rd_word*16 +: 16];
        default: wb_dat_o <= 16'h0000;
      endcase
    end
  end

  // software loaded address, mask and write burst
  always_ff @(posedge dram_clk0) begin
    if (wr_access) begin
      case (idx) inside
        7'd2: addr_buf[31:16] <= lane_merge(addr_buf[31:16], wb_req_i.dat, wb_req_i.sel);
        7'd3: addr_buf[15:0]  <= lane_merge(addr_buf[15:0], wb_req_i.dat, wb_req_i.sel);
        7'd5: mask_buf[47:32] <= lane_merge(mask_buf[47:32], wb_req_i.dat, wb_req_i.sel);
        7'd6: mask_buf[31:16] <= lane_merge(mask_buf[31:16], wb_req_i.dat, wb_req_i.sel);
        7'd7: mask_buf[15:0]  <= lane_merge(mask_buf[15:0], wb_req_i.dat, wb_req_i.sel);
        [WR_BASE:RD_BASE-1]: begin
          wr_buf[wr_word*16 +: 16] <= lane_merge(wr_buf[wr_word*16 +: 16], wb_req_i.dat,
                                                 wb_req_i.sel);
        end
        default: ;
      endcase
    end
  end

  // a pending request goes out once the PHY is up and out of reset
  assign issue = (state == ST_IDLE) && (wr_busy || rd_busy) && phy_ready_i && !dram_rst_i;

  always_ff @(posedge dram_clk0) begin
    if (wb_rst_i) begin
      state      <= ST_IDLE;
      wr_busy    <= 1'b0;
      rd_busy    <= 1'b0;
      cur_rnw    <= 1'b0;
      rd_beat    <= 1'b0;
      cmd_done_o <= 1'b0;
    end else begin
      cmd_done_o <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (issue) begin
            // write wins when both are pending
            cur_rnw <= !wr_busy;
            state   <= ST_CMD;
          end
        end
        ST_CMD: begin
          rd_beat <= 1'b0;
          state   <= cur_rnw ? ST_RD_WAIT : ST_WR_HI;
        end
        ST_WR_HI: begin
          wr_busy    <= 1'b0;
          cmd_done_o <= 1'b1;
          state      <= ST_IDLE;
        end
        ST_RD_WAIT: begin
          if (dram_rd_valid_i) begin
            rd_beat <= 1'b1;
            if (rd_beat) begin
              rd_busy    <= 1'b0;
              cmd_done_o <= 1'b1;
              state      <= ST_IDLE;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
      // a new request overrides a completion on the same edge
      if (wr_access && idx == 7'd0 && wb_req_i.dat[0]) begin
        wr_busy <= 1'b1;
      end
      if (wr_access && idx == 7'd1 && wb_req_i.dat[0]) begin
        rd_busy <= 1'b1;
      end
    end
  end

  // first beat is words 0 to 8, second beat words 9 to 17
  always_ff @(posedge dram_clk0) begin
    if (state == ST_RD_WAIT && dram_rd_valid_i) begin
      if (rd_beat) begin
        rd_buf[BURST_W-1:BEAT_W] <= dram_rd_data_i;
      end else begin
        rd_buf[BEAT_W-1:0] <= dram_rd_data_i;
      end
    end
  end

  // low half goes with the command, high half one cycle later
  assign beat_hi = (state == ST_WR_HI);

  always_comb begin
    dram_cmd_o.valid   = (state == ST_CMD);
    dram_cmd_o.rnw     = cur_rnw;
    dram_cmd_o.addr    = addr_buf;
    dram_cmd_o.wr_data = beat_hi ? wr_buf[BURST_W-1:BEAT_W] : wr_buf[BEAT_W-1:0];
    dram_cmd_o.wr_be   = beat_hi ? mask_buf[2*BE_W-1:BE_W] : mask_buf[BE_W-1:0];
  end

  // PHY reset comes from the reset controller
  a_no_cmd_in_rst: assert property (
    @(posedge dram_clk0) disable iff (wb_rst_i) $rose(dram_cmd_o.valid) |-> !dram_rst_i
  ) else $error("command issued while PHY in reset");

  // read data from the PHY only for a read we sent
  a_rd_only_busy: assert property (
    @(posedge dram_clk0) disable iff (wb_rst_i) dram_rd_valid_i |-> rd_busy
  ) else $error("dram_rd_valid without an outstanding read");

endmodule

//--- source/dram_reset_ctrl.sv
`timescale 1ns/1ps

module dram_reset_ctrl (
  input  logic dram_clk0,
  input  logic wb_rst_i,
  input  logic soft_rst_i,
  output logic dram_rst_o
);

  logic [7:0] stretch;
  logic       rst_req;

  // system reset and soft reset both restart the stretch
  assign rst_req = wb_rst_i | soft_rst_i;

  // a request reloads all ones, then zeros shift in from the bottom
  always_ff @(posedge dram_clk0) begin
    if (rst_req) begin
      stretch <= 8'hff;
    end else begin
      stretch <= {stretch[6:0], 1'b0};
    end
  end

  assign dram_rst_o = stretch[7];

  // PHY needs at least eight cycles of reset
  a_rst_min_width: assert property (
    @(posedge dram_clk0) $rose(dram_rst_o) |-> dram_rst_o [*8]
  ) else $error("dram_rst_o pulse shorter than 8 cycles");

endmodule

//--- source/dram_reg_wb_attach.sv
`timescale 1ns/1ps

module dram_reg_wb_attach (
  input  logic                   dram_clk0,
  input  logic                   wb_rst_i,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  dram_pkg::wb_req_t      wb_req_i,
  output logic [15:0]            wb_dat_o,
  output logic                   wb_ack_o,
  input  dram_pkg::dram_status_t status_i,
  input  logic                   cmd_done_i,
  output logic                   soft_rst_o
);

  logic [6:0]  idx;
  logic        accept;
  logic [15:0] cmd_count;

  // register index in 16-bit words
  assign idx = wb_req_i.adr[7:1];

  // new request only, never while our own ack is up
  assign accept = wb_cyc_i & wb_stb_i & ~wb_ack_o;

  always_ff @(posedge dram_clk0) begin
    if (wb_rst_i) begin
      wb_ack_o   <= 1'b0;
      soft_rst_o <= 1'b0;
    end else begin
      wb_ack_o   <= accept;
      soft_rst_o <= 1'b0;
      // bit 0 of register 0 kicks the PHY reset stretcher
      if (accept && wb_req_i.we && idx == 7'd0 && wb_req_i.sel[0] && wb_req_i.dat[0]) begin
        soft_rst_o <= 1'b1;
      end
    end
  end

  // read data, valid while ack is high
  always_ff @(posedge dram_clk0) begin
    if (accept && !wb_req_i.we) begin
      case (idx)
        7'd0: begin
          wb_dat_o <= {14'h0000, status_i.cal_fail, status_i.phy_ready};
        end
        7'd1: begin
          wb_dat_o <= cmd_count;
        end
        default: begin
          wb_dat_o <= 16'h0000;
        end
      endcase
    end
  end

  // completed commands, free running and wrapping
  always_ff @(posedge dram_clk0) begin
    if (wb_rst_i) begin
      cmd_count <= 16'h0000;
    end else if (cmd_done_i) begin
      cmd_count <= cmd_count + 16'd1;
    end
  end

endmodule

//--- source/dram_pkg.sv
`include "dram_config.svh"

package dram_pkg;

  // one Wishbone request as driven by the bus master
  typedef struct packed {
    logic        we;
    logic [1:0]  sel;
    logic [31:0] adr;
    logic [15:0] dat;
  } wb_req_t;

  // command and write data toward the DRAM application interface
  typedef struct packed {
    logic                         valid;
    logic                         rnw;
    logic [31:0]                  addr;
    logic [`DRAM_BEAT_WIDTH-1:0]  wr_data;
    logic [`DRAM_BE_WIDTH-1:0]    wr_be;
  } dram_cmd_t;

  // PHY status flags
  typedef struct packed {
    logic phy_ready;
    logic cal_fail;
  } dram_status_t;

endpackage

//--- source/dram_config.svh
`ifndef DRAM_CONFIG_SVH
`define DRAM_CONFIG_SVH

// PHY data width on one clock edge
`define DRAM_DQ_WIDTH 72

// data units in one burst
`define DRAM_BURST_LEN 4

// one application beat carries both edges
`define DRAM_BEAT_WIDTH (2 * `DRAM_DQ_WIDTH)

// whole burst, two beats
`define DRAM_BURST_BITS (`DRAM_DQ_WIDTH * `DRAM_BURST_LEN)

// 16-bit bus words per burst
`define DRAM_BURST_WORDS (`DRAM_BURST_BITS / 16)

// byte enables per beat
`define DRAM_BE_WIDTH (`DRAM_BEAT_WIDTH / 8)

// mask buffer seen by software as three words
`define DRAM_MASK_WORDS 3

`endif
